// File: logic/audio_pkg.sv
// Shared widths and depths; sample words carry left in the upper half, right in the lower half.
`default_nettype none

package audio_pkg;

	localparam int AUDIO_ADDR_W       = 32;
	localparam int AUDIO_COUNT_W      = 24;
	localparam int AUDIO_WORD_W       = 32;
	localparam int AUDIO_SAMPLE_W     = 16;
	localparam int AUDIO_CMDQ_DEPTH   = 4;
	localparam int AUDIO_FIFO_DEPTH   = 4;
	localparam int AUDIO_NUM_CHANNELS = 2;
	localparam int AUDIO_WORD_BYTES   = 4;

	// Pointer widths derived from the depths.
	localparam int AUDIO_CMDQ_PTR_W = $clog2(AUDIO_CMDQ_DEPTH);
	localparam int AUDIO_FIFO_PTR_W = $clog2(AUDIO_FIFO_DEPTH);

	// One bus word, seen either raw or as a stereo pair.
	typedef union packed {
		logic [AUDIO_WORD_W-1:0] word;
		struct packed {
			logic [AUDIO_SAMPLE_W-1:0] left;
			logic [AUDIO_SAMPLE_W-1:0] right;
		} stereo;
	} audio_sample_u;

endpackage

`default_nettype wire

// File: logic/audio_cmdq.sv
// Zero-count commands are ignored and appends to a full queue are dropped silently.
`timescale 1ns/1ps
`default_nettype none

module audio_cmdq (
	input  wire                              i_clock,
	input  wire                              i_rst_n,
	input  wire                              i_setup_request,
	input  wire                              i_setup_replace,
	input  wire [audio_pkg::AUDIO_ADDR_W-1:0]  i_setup_address,
	input  wire [audio_pkg::AUDIO_COUNT_W-1:0] i_setup_count,
	input  wire                              i_next_ready,
	output logic                             o_next_have,
	output logic [audio_pkg::AUDIO_ADDR_W-1:0]  o_next_address,
	output logic [audio_pkg::AUDIO_COUNT_W-1:0] o_next_count,
	output logic                             o_pending
);
	import audio_pkg::*;

	logic [AUDIO_ADDR_W-1:0]  addr_mem [AUDIO_CMDQ_DEPTH];
	logic [AUDIO_COUNT_W-1:0] count_mem [AUDIO_CMDQ_DEPTH];
	logic [AUDIO_CMDQ_PTR_W-1:0] head;
	logic [AUDIO_CMDQ_PTR_W-1:0] tail;
	logic [AUDIO_CMDQ_PTR_W:0]   used;
	logic push;
	logic do_append;
	logic do_replace;
	logic pop;

	assign push       = i_setup_request && (i_setup_count != '0);
	assign do_replace = push && i_setup_replace;
	assign do_append  = push && !i_setup_replace && (used != AUDIO_CMDQ_DEPTH);
	assign o_pending  = (used != '0);
	assign pop        = i_next_ready && o_pending;

	// Head command is offered whenever the channel is idle.
	assign o_next_have    = pop;
	assign o_next_address = addr_mem[head];
	assign o_next_count   = count_mem[head];

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			head <= '0;
			tail <= '0;
			used <= '0;
		end else if (do_replace) begin
			// Pending commands are discarded, new one lands in slot 0.
			head <= '0;
			tail <= AUDIO_CMDQ_PTR_W'(1);
			used <= (AUDIO_CMDQ_PTR_W + 1)'(1);
		end else begin
			if (do_append)
				tail <= tail + 1'b1;
			if (pop)
				head <= head + 1'b1;
			if (do_append && !pop)
				used <= used + 1'b1;
			else if (pop && !do_append)
				used <= used - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (do_replace) begin
			addr_mem[0]  <= i_setup_address;
			count_mem[0] <= i_setup_count;
		end else if (do_append) begin
			addr_mem[tail]  <= i_setup_address;
			count_mem[tail] <= i_setup_count;
		end
	end

endmodule

`default_nettype wire

// File: logic/audio_sample_fifo.sv
// Writes into a full FIFO are not guarded; the almost-full flag must stop the writer in time.
`timescale 1ns/1ps
`default_nettype none

module audio_sample_fifo (
	input  wire                        i_clock,
	input  wire                        i_rst_n,
	input  wire                        i_write,
	input  wire audio_pkg::audio_sample_u i_wdata,
	input  wire                        i_read,
	output audio_pkg::audio_sample_u   o_rdata,
	output logic                       o_empty,
	output logic                       o_almost_full
);
	import audio_pkg::*;

	audio_sample_u mem [AUDIO_FIFO_DEPTH];
	logic [AUDIO_FIFO_PTR_W-1:0] rd_ptr;
	logic [AUDIO_FIFO_PTR_W-1:0] wr_ptr;
	logic [AUDIO_FIFO_PTR_W:0]   level;
	logic do_read;

	assign do_read       = i_read && !o_empty;
	assign o_empty       = (level == '0);
	// One free slot left covers the word already on the bus.
	assign o_almost_full = (level >= AUDIO_FIFO_DEPTH - 1);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			level  <= '0;
		end else begin
			if (i_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			if (i_write && !do_read)
				level <= level + 1'b1;
			else if (do_read && !i_write)
				level <= level - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_write)
			mem[wr_ptr] <= i_wdata;
		if (do_read)
			o_rdata <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// File: logic/audio_channel.sv
// Sample clock must already be synchronous to i_clock; 16-bit stereo words only, no bus errors.
`timescale 1ns/1ps
`default_nettype none

module audio_channel (
	input  wire                              i_clock,
	input  wire                              i_rst_n,
	input  wire                              i_setup_request,
	input  wire                              i_setup_replace,
	input  wire [audio_pkg::AUDIO_ADDR_W-1:0]  i_setup_address,
	input  wire [audio_pkg::AUDIO_COUNT_W-1:0] i_setup_count,
	output logic                             o_dma_request,
	output logic [audio_pkg::AUDIO_ADDR_W-1:0] o_dma_address,
	input  wire                              i_dma_ready,
	input  wire [audio_pkg::AUDIO_WORD_W-1:0]  i_dma_rdata,
	input  wire                              i_sample_clock,
	output logic                             o_busy,
	output audio_pkg::audio_sample_u         o_sample
);
	import audio_pkg::*;

	logic [AUDIO_ADDR_W-1:0]  address;
	logic [AUDIO_COUNT_W-1:0] count;
	logic                     cmd_have;
	logic [AUDIO_ADDR_W-1:0]  cmd_address;
	logic [AUDIO_COUNT_W-1:0] cmd_count;
	logic                     cmd_pending;
	logic                     word_done;
	logic                     fifo_read;
	logic                     fifo_empty;
	logic                     fifo_almost_full;
	audio_sample_u            fifo_rdata;
	logic                     last_sample_clock;
	logic                     tick;
	logic                     read_q;

	audio_cmdq u_cmdq (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_setup_request (i_setup_request),
		.i_setup_replace (i_setup_replace),
		.i_setup_address (i_setup_address),
		.i_setup_count   (i_setup_count),
		.i_next_ready    (count == '0),
		.o_next_have     (cmd_have),
		.o_next_address  (cmd_address),
		.o_next_count    (cmd_count),
		.o_pending       (cmd_pending)
	);

	audio_sample_fifo u_sample_fifo (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_write       (word_done),
		.i_wdata       (i_dma_rdata),
		.i_read        (fifo_read),
		.o_rdata       (fifo_rdata),
		.o_empty       (fifo_empty),
		.o_almost_full (fifo_almost_full)
	);

	assign word_done     = o_dma_request && i_dma_ready;
	assign o_dma_address = address;
	assign o_busy        = cmd_pending || (count != '0);

	// Fetch engine. Request drops for a cycle after every completed word.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			count         <= '0;
			o_dma_request <= 1'b0;
		end else begin
			o_dma_request <= !word_done && !fifo_almost_full && (count != '0);
			if (cmd_have)
				count <= cmd_count;
			else if (word_done)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (cmd_have)
			address <= cmd_address;
		else if (word_done)
			address <= address + AUDIO_ADDR_W'(AUDIO_WORD_BYTES);
	end

	// Playout. tick is the registered toggle detection.
	assign fifo_read = tick && !fifo_empty;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			last_sample_clock <= 1'b0;
			tick              <= 1'b0;
			read_q            <= 1'b0;
			o_sample          <= '0;
		end else begin
			last_sample_clock <= i_sample_clock;
			tick              <= (i_sample_clock != last_sample_clock);
			read_q            <= fifo_read;
			if (read_q) begin
				o_sample.stereo.left  <= fifo_rdata.stereo.left;
				o_sample.stereo.right <= fifo_rdata.stereo.right;
			end else if (tick && fifo_empty) begin
				// Underrun plays silence.
				o_sample <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/audio_bus_arbiter.sv
// Exactly two requesters; a grant is held until its request drops, costing one idle cycle.
`timescale 1ns/1ps
`default_nettype none

module audio_bus_arbiter (
	input  wire                              i_clock,
	input  wire                              i_rst_n,
	input  wire                              i_request_0,
	input  wire                              i_request_1,
	input  wire [audio_pkg::AUDIO_ADDR_W-1:0]  i_address_0,
	input  wire [audio_pkg::AUDIO_ADDR_W-1:0]  i_address_1,
	output logic                             o_ready_0,
	output logic                             o_ready_1,
	output logic [audio_pkg::AUDIO_WORD_W-1:0] o_rdata_0,
	output logic [audio_pkg::AUDIO_WORD_W-1:0] o_rdata_1,
	output logic                             o_dma_request,
	output logic [audio_pkg::AUDIO_ADDR_W-1:0] o_dma_address,
	input  wire                              i_dma_ready,
	input  wire [audio_pkg::AUDIO_WORD_W-1:0]  i_dma_rdata
);
	import audio_pkg::*;

	logic grant_valid;
	logic grant_id;
	logic last_winner;
	logic granted_request;
	logic next_pick;

	assign granted_request = grant_id ? i_request_1 : i_request_0;
	// On a tie, the channel that lost last time wins.
	assign next_pick = (i_request_0 && i_request_1) ? !last_winner : i_request_1;

	assign o_dma_request = grant_valid && granted_request;
	assign o_dma_address = grant_id ? i_address_1 : i_address_0;
	assign o_ready_0     = grant_valid && !grant_id && i_dma_ready;
	assign o_ready_1     = grant_valid && grant_id && i_dma_ready;
	assign o_rdata_0     = (grant_valid && !grant_id) ? i_dma_rdata : '0;
	assign o_rdata_1     = (grant_valid && grant_id) ? i_dma_rdata : '0;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			grant_valid <= 1'b0;
			grant_id    <= 1'b0;
			last_winner <= 1'b1;
		end else if (!grant_valid) begin
			if (i_request_0 || i_request_1) begin
				grant_valid <= 1'b1;
				grant_id    <= next_pick;
				last_winner <= next_pick;
			end
		end else if (!granted_request) begin
			grant_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/audio_mixer.sv
// Two inputs only, unity gain; each sum is clamped to the signed 16-bit range.
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input  wire                          i_clock,
	input  wire                          i_rst_n,
	input  wire audio_pkg::audio_sample_u i_sample_0,
	input  wire audio_pkg::audio_sample_u i_sample_1,
	output logic [audio_pkg::AUDIO_SAMPLE_W-1:0] o_sample_left,
	output logic [audio_pkg::AUDIO_SAMPLE_W-1:0] o_sample_right
);
	import audio_pkg::*;

	logic [AUDIO_SAMPLE_W:0]   sum_left;
	logic [AUDIO_SAMPLE_W:0]   sum_right;
	logic [AUDIO_SAMPLE_W-1:0] sat_left;
	logic [AUDIO_SAMPLE_W-1:0] sat_right;

	// Sign-extended to 17 bits, so the sum cannot wrap.
	assign sum_left  = {i_sample_0.stereo.left[AUDIO_SAMPLE_W-1], i_sample_0.stereo.left}
		+ {i_sample_1.stereo.left[AUDIO_SAMPLE_W-1], i_sample_1.stereo.left};
	assign sum_right = {i_sample_0.stereo.right[AUDIO_SAMPLE_W-1], i_sample_0.stereo.right}
		+ {i_sample_1.stereo.right[AUDIO_SAMPLE_W-1], i_sample_1.stereo.right};

	// Top two bits differ on overflow; bit 16 gives the direction.
	assign sat_left = (sum_left[AUDIO_SAMPLE_W] == sum_left[AUDIO_SAMPLE_W-1])
		? sum_left[AUDIO_SAMPLE_W-1:0]
		: {sum_left[AUDIO_SAMPLE_W], {(AUDIO_SAMPLE_W-1){!sum_left[AUDIO_SAMPLE_W]}}};
	assign sat_right = (sum_right[AUDIO_SAMPLE_W] == sum_right[AUDIO_SAMPLE_W-1])
		? sum_right[AUDIO_SAMPLE_W-1:0]
		: {sum_right[AUDIO_SAMPLE_W], {(AUDIO_SAMPLE_W-1){!sum_right[AUDIO_SAMPLE_W]}}};

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sample_left  <= '0;
			o_sample_right <= '0;
		end else begin
			o_sample_left  <= sat_left;
			o_sample_right <= sat_right;
		end
	end

endmodule

`default_nettype wire

// File: logic/audio_subsystem.sv
// Two channels share one bus port; output lags a sample-clock toggle by 3 cycles, 2 on underrun.
`timescale 1ns/1ps
`default_nettype none

module audio_subsystem (
	input  wire                              i_clock,
	input  wire                              i_rst_n,
	input  wire                              i_setup_request_0,
	input  wire                              i_setup_replace_0,
	input  wire [audio_pkg::AUDIO_ADDR_W-1:0]  i_setup_address_0,
	input  wire [audio_pkg::AUDIO_COUNT_W-1:0] i_setup_count_0,
	input  wire                              i_setup_request_1,
	input  wire                              i_setup_replace_1,
	input  wire [audio_pkg::AUDIO_ADDR_W-1:0]  i_setup_address_1,
	input  wire [audio_pkg::AUDIO_COUNT_W-1:0] i_setup_count_1,
	output logic                             o_dma_request,
	output logic [audio_pkg::AUDIO_ADDR_W-1:0] o_dma_address,
	input  wire                              i_dma_ready,
	input  wire [audio_pkg::AUDIO_WORD_W-1:0]  i_dma_rdata,
	input  wire                              i_sample_clock,
	output logic                             o_busy_0,
	output logic                             o_busy_1,
	output logic [audio_pkg::AUDIO_SAMPLE_W-1:0] o_sample_left,
	output logic [audio_pkg::AUDIO_SAMPLE_W-1:0] o_sample_right
);
	import audio_pkg::*;

	logic                    request_0;
	logic                    request_1;
	logic [AUDIO_ADDR_W-1:0] address_0;
	logic [AUDIO_ADDR_W-1:0] address_1;
	logic                    ready_0;
	logic                    ready_1;
	logic [AUDIO_WORD_W-1:0] rdata_0;
	logic [AUDIO_WORD_W-1:0] rdata_1;
	audio_sample_u           sample_0;
	audio_sample_u           sample_1;

	audio_channel u_channel_0 (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_setup_request (i_setup_request_0),
		.i_setup_replace (i_setup_replace_0),
		.i_setup_address (i_setup_address_0),
		.i_setup_count   (i_setup_count_0),
		.o_dma_request   (request_0),
		.o_dma_address   (address_0),
		.i_dma_ready     (ready_0),
		.i_dma_rdata     (rdata_0),
		.i_sample_clock  (i_sample_clock),
		.o_busy          (o_busy_0),
		.o_sample        (sample_0)
	);

	audio_channel u_channel_1 (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_setup_request (i_setup_request_1),
		.i_setup_replace (i_setup_replace_1),
		.i_setup_address (i_setup_address_1),
		.i_setup_count   (i_setup_count_1),
		.o_dma_request   (request_1),
		.o_dma_address   (address_1),
		.i_dma_ready     (ready_1),
		.i_dma_rdata     (rdata_1),
		.i_sample_clock  (i_sample_clock),
		.o_busy          (o_busy_1),
		.o_sample        (sample_1)
	);

	audio_bus_arbiter u_bus_arbiter (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_request_0   (request_0),
		.i_request_1   (request_1),
		.i_address_0   (address_0),
		.i_address_1   (address_1),
		.o_ready_0     (ready_0),
		.o_ready_1     (ready_1),
		.o_rdata_0     (rdata_0),
		.o_rdata_1     (rdata_1),
		.o_dma_request (o_dma_request),
		.o_dma_address (o_dma_address),
		.i_dma_ready   (i_dma_ready),
		.i_dma_rdata   (i_dma_rdata)
	);

	audio_mixer u_mixer (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_sample_0     (sample_0),
		.i_sample_1     (sample_1),
		.o_sample_left  (o_sample_left),
		.o_sample_right (o_sample_right)
	);

endmodule

`default_nettype wire

// File: dv/audio_properties.sv
// Bound into audio_subsystem; grant checks use the per-channel request and ready nets.
`timescale 1ns/1ps
`default_nettype none

module audio_properties (
	input wire                             i_clock,
	input wire                             i_rst_n,
	input wire                             i_dma_request,
	input wire [audio_pkg::AUDIO_ADDR_W-1:0] i_dma_address,
	input wire                             i_dma_ready,
	input wire                             i_request_0,
	input wire                             i_request_1,
	input wire                             i_ready_0,
	input wire                             i_ready_1,
	input wire                             i_busy_0,
	input wire                             i_busy_1
);
	int failure_count = 0;

	// Request and address hold while the bus waits for ready.
	property address_held;
		@(posedge i_clock) disable iff (!i_rst_n)
		(i_dma_request && !i_dma_ready) |=> (i_dma_request && $stable(i_dma_address));
	endproperty

	// Ready goes to one channel only, and only to one that is requesting.
	property single_grant;
		@(posedge i_clock) disable iff (!i_rst_n)
		!(i_ready_0 && i_ready_1) && (!i_ready_0 || i_request_0)
			&& (!i_ready_1 || i_request_1);
	endproperty

	// Idle on the first cycle out of reset.
	property idle_after_reset;
		@(posedge i_clock)
		$rose(i_rst_n) |-> (!i_busy_0 && !i_busy_1 && !i_dma_request);
	endproperty

	assert property (address_held)
	else begin
		failure_count++;
		$error("Bus request or address changed before ready");
	end

	assert property (single_grant)
	else begin
		failure_count++;
		$error("Ready reached both channels or a channel that was not requesting");
	end

	assert property (idle_after_reset)
	else begin
		failure_count++;
		$error("Busy or bus request high right after reset");
	end

endmodule

bind audio_subsystem audio_properties u_audio_properties (
	.i_clock       (i_clock),
	.i_rst_n       (i_rst_n),
	.i_dma_request (o_dma_request),
	.i_dma_address (o_dma_address),
	.i_dma_ready   (i_dma_ready),
	.i_request_0   (request_0),
	.i_request_1   (request_1),
	.i_ready_0     (ready_0),
	.i_ready_1     (ready_1),
	.i_busy_0      (o_busy_0),
	.i_busy_1      (o_busy_1)
);

`default_nettype wire

// File: dv/audio_tb.sv
// Memory answers in 0 to 3 cycles; outputs are checked 4 cycles after each 40-cycle sample tick.
`timescale 1ns/1ps
`default_nettype none

module audio_tb;
	import audio_pkg::*;

	localparam int TICK_CYCLES     = 40;
	localparam int CHECK_DELAY     = 4;
	localparam int TOTAL_TICKS     = 52;
	localparam int SEED            = 19;
	localparam int WATCHDOG_CYCLES = TOTAL_TICKS * TICK_CYCLES + 400;

	logic clock = 1'b0;
	logic rst_n;
	logic setup_request [2];
	logic setup_replace [2];
	logic [AUDIO_ADDR_W-1:0]  setup_address [2];
	logic [AUDIO_COUNT_W-1:0] setup_count [2];
	logic dma_request;
	logic [AUDIO_ADDR_W-1:0] dma_address;
	logic dma_ready = 1'b0;
	logic [AUDIO_WORD_W-1:0] dma_rdata = '0;
	logic sample_clock;
	logic busy [2];
	logic [AUDIO_SAMPLE_W-1:0] sample_left;
	logic [AUDIO_SAMPLE_W-1:0] sample_right;

	// Words each channel should play, in order.
	logic [31:0] expected_words_0 [$];
	logic [31:0] expected_words_1 [$];
	string test_name = "reset";
	int check_count = 0;
	int error_count = 0;
	event sample_tick;

	audio_subsystem u_audio_subsystem (
		.i_clock           (clock),
		.i_rst_n           (rst_n),
		.i_setup_request_0 (setup_request[0]),
		.i_setup_replace_0 (setup_replace[0]),
		.i_setup_address_0 (setup_address[0]),
		.i_setup_count_0   (setup_count[0]),
		.i_setup_request_1 (setup_request[1]),
		.i_setup_replace_1 (setup_replace[1]),
		.i_setup_address_1 (setup_address[1]),
		.i_setup_count_1   (setup_count[1]),
		.o_dma_request     (dma_request),
		.o_dma_address     (dma_address),
		.i_dma_ready       (dma_ready),
		.i_dma_rdata       (dma_rdata),
		.i_sample_clock    (sample_clock),
		.o_busy_0          (busy[0]),
		.o_busy_1          (busy[1]),
		.o_sample_left     (sample_left),
		.o_sample_right    (sample_right)
	);

	always #2 clock = !clock;

	// Left is three times the word index, right is its negation plus 7.
	function automatic logic [31:0] memory_word(input logic [31:0] address);
		logic [15:0] left;
		logic [15:0] right;
		left  = 16'((address >> 2) * 3) ^ address[31:16];
		right = 16'd7 - left;
		return {left, right};
	endfunction

	function automatic logic [15:0] clamp_sample(input int value);
		if (value > 32767)
			return 16'h7fff;
		if (value < -32768)
			return 16'h8000;
		return 16'(value);
	endfunction

	// Expected mixer output for one tick.
	function automatic logic [31:0] mix_reference(input logic [31:0] word_0,
			input logic [31:0] word_1);
		int sum_left;
		int sum_right;
		sum_left  = int'($signed(word_0[31:16])) + int'($signed(word_1[31:16]));
		sum_right = int'($signed(word_0[15:0])) + int'($signed(word_1[15:0]));
		return {clamp_sample(sum_left), clamp_sample(sum_right)};
	endfunction

	task automatic issue_command(input int channel, input logic replace,
			input logic [31:0] address, input int count, input logic will_play);
		int i;
		@(negedge clock);
		setup_request[channel] = 1'b1;
		setup_replace[channel] = replace;
		setup_address[channel] = address;
		setup_count[channel]   = AUDIO_COUNT_W'(count);
		@(negedge clock);
		setup_request[channel] = 1'b0;
		setup_replace[channel] = 1'b0;
		for (i = 0; i < count && will_play; i++) begin
			if (channel == 0)
				expected_words_0.push_back(memory_word(address + 32'(4 * i)));
			else
				expected_words_1.push_back(memory_word(address + 32'(4 * i)));
		end
	endtask

	task automatic play_ticks(input int ticks);
		repeat (ticks) begin
			repeat (TICK_CYCLES) @(negedge clock);
			sample_clock = !sample_clock;
			-> sample_tick;
		end
	endtask

	task automatic check_busy(input int channel, input logic expected);
		check_count++;
		assert (busy[channel] == expected)
		else begin
			error_count++;
			$display("FAIL %s: busy_%0d expected %0b, actual %0b", test_name, channel,
				expected, busy[channel]);
		end
	endtask

	// Bus memory with a random answer delay.
	always begin : memory_model
		int delay;
		@(negedge clock);
		dma_ready = 1'b0;
		if (dma_request) begin
			delay = $urandom % 4;
			repeat (delay) @(negedge clock);
			dma_rdata = memory_word(dma_address);
			dma_ready = 1'b1;
		end
	end

	// Pops each channel's model at the tick, compares once the output has settled.
	always @(sample_tick) begin : compare_outputs
		logic [31:0] word_0;
		logic [31:0] word_1;
		logic [31:0] expected;
		logic [31:0] actual;
		string name;
		word_0 = '0;
		word_1 = '0;
		if (expected_words_0.size() > 0)
			word_0 = expected_words_0.pop_front();
		if (expected_words_1.size() > 0)
			word_1 = expected_words_1.pop_front();
		name     = test_name;
		expected = mix_reference(word_0, word_1);
		repeat (CHECK_DELAY) @(negedge clock);
		actual = {sample_left, sample_right};
		check_count++;
		assert (actual == expected)
		else begin
			error_count++;
			$display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : stimulus
		int assert_failures;
		void'($urandom(SEED));
		rst_n        = 1'b0;
		sample_clock = 1'b0;
		for (int c = 0; c < 2; c++) begin
			setup_request[c] = 1'b0;
			setup_replace[c] = 1'b0;
			setup_address[c] = '0;
			setup_count[c]   = '0;
		end
		repeat (10) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		check_count++;
		assert (!dma_request && !busy[0] && !busy[1] && sample_left == '0 && sample_right == '0)
		else begin
			error_count++;
			$display("Outputs were not idle after reset");
		end

		test_name = "underrun_idle";
		play_ticks(2);

		test_name = "single_channel";
		issue_command(0, 1'b0, 32'h1000, 6, 1'b1);
		check_busy(0, 1'b1);
		check_busy(1, 1'b0);
		play_ticks(6);
		test_name = "underrun_tail";
		play_ticks(2);

		test_name = "append";
		issue_command(0, 1'b0, 32'h2000, 4, 1'b1);
		issue_command(0, 1'b0, 32'h3000, 5, 1'b1);
		play_ticks(9);
		check_busy(0, 1'b0);
		// Zero-count command leaves the channel idle.
		issue_command(0, 1'b0, 32'h8000, 0, 1'b0);
		check_busy(0, 1'b0);

		test_name = "replace";
		issue_command(0, 1'b0, 32'h4000, 10, 1'b1);
		issue_command(0, 1'b0, 32'h5000, 4, 1'b0);
		issue_command(0, 1'b0, 32'h6000, 4, 1'b0);
		play_ticks(2);
		issue_command(0, 1'b1, 32'h7000, 3, 1'b1);
		play_ticks(12);
		check_busy(0, 1'b0);

		// Regions near index 10000 clamp both sides.
		test_name = "mixing";
		issue_command(0, 1'b0, 32'h9c40, 5, 1'b1);
		issue_command(1, 1'b0, 32'ha410, 5, 1'b1);
		play_ticks(6);

		// Small indices keep the sums unclamped, so every word shows.
		test_name = "sharing";
		issue_command(0, 1'b0, 32'h0b00, 12, 1'b1);
		issue_command(1, 1'b0, 32'h0c00, 9, 1'b1);
		play_ticks(13);
		check_busy(0, 1'b0);
		check_busy(1, 1'b0);

		repeat (CHECK_DELAY + 2) @(negedge clock);
		assert_failures = u_audio_subsystem.u_audio_properties.failure_count;
		$display("Checks: %0d, errors: %0d, property failures: %0d", check_count,
			error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: audio_dma.f
logic/audio_pkg.sv
logic/audio_cmdq.sv
logic/audio_sample_fifo.sv
logic/audio_channel.sv
logic/audio_bus_arbiter.sv
logic/audio_mixer.sv
logic/audio_subsystem.sv
dv/audio_properties.sv
dv/audio_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module audio_tb \
	-f audio_dma.f -o audio_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/audio_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
